/* src/cpuPkg.sv */
package cpuPkg;

	localparam int WORD_WIDTH = 16;
	localparam int PC_WIDTH = 8;
	localparam int MEM_DEPTH = 256;

	typedef logic [WORD_WIDTH-1:0] wordT;
	typedef logic [WORD_WIDTH-1:0] instrT;
	typedef logic [3:0] regAddrT;
	typedef logic [PC_WIDTH-1:0] pcT;
	typedef logic [$clog2(MEM_DEPTH)-1:0] memAddrT;
	typedef logic [4:0] flagsT;
	typedef logic [3:0] aluOpT;
	typedef logic [3:0] condT;

	// **************************************************
	// ALU operation codes.
	// **************************************************
	localparam aluOpT OP_ADD = 4'd0;
	localparam aluOpT OP_SUB = 4'd1;
	localparam aluOpT OP_CMP = 4'd2;
	localparam aluOpT OP_AND = 4'd3;
	localparam aluOpT OP_OR = 4'd4;
	localparam aluOpT OP_XOR = 4'd5;
	localparam aluOpT OP_NOT = 4'd6;
	localparam aluOpT OP_LSH = 4'd7;
	localparam aluOpT OP_RSH = 4'd8;
	localparam aluOpT OP_ARSH = 4'd9;
	localparam aluOpT OP_MUL = 4'd10;

	// opcode classes, upper nibble of the instruction.
	localparam logic [3:0] CLASS_REG = 4'b0000;
	localparam logic [3:0] CLASS_MEM = 4'b0100;
	localparam logic [3:0] CLASS_BCOND = 4'b1100;

	// function codes; the immediate class and the register-form extension share them.
	localparam logic [3:0] FN_AND = 4'b0001;
	localparam logic [3:0] FN_OR = 4'b0010;
	localparam logic [3:0] FN_XOR = 4'b0011;
	localparam logic [3:0] FN_ADD = 4'b0101;
	localparam logic [3:0] FN_ADDU = 4'b0110;
	localparam logic [3:0] FN_ADDC = 4'b0111;
	localparam logic [3:0] FN_SUB = 4'b1001;
	localparam logic [3:0] FN_SUBC = 4'b1010;
	localparam logic [3:0] FN_CMP = 4'b1011;
	localparam logic [3:0] FN_MUL = 4'b1110;

	localparam logic [3:0] EXT_LOAD = 4'b0000;
	localparam logic [3:0] EXT_STOR = 4'b0100;
	localparam logic [3:0] EXT_JCOND = 4'b1100;
	localparam logic [3:0] EXT_SCOND = 4'b1101;

	localparam int FLAG_C = 0;
	localparam int FLAG_L = 1;
	localparam int FLAG_F = 2;
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 4;

	localparam condT COND_EQ = 4'd0;
	localparam condT COND_NE = 4'd1;
	localparam condT COND_CS = 4'd2;
	localparam condT COND_CC = 4'd3;
	localparam condT COND_LO = 4'd4;
	localparam condT COND_HS = 4'd5;
	localparam condT COND_LT = 4'd6;
	localparam condT COND_GE = 4'd7;
	localparam condT COND_FS = 4'd8;
	localparam condT COND_FC = 4'd9;
	localparam condT COND_HI = 4'd10;
	localparam condT COND_LS = 4'd11;
	localparam condT COND_GT = 4'd12;
	localparam condT COND_LE = 4'd13;
	localparam condT COND_UC = 4'd14;
	localparam condT COND_NV = 4'd15;

	// register write data sources.
	localparam logic [1:0] WR_ALU = 2'b00;
	localparam logic [1:0] WR_MEM = 2'b01;
	localparam logic [1:0] WR_COND = 2'b10;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		OPERAND,
		EXEC_REG,
		EXEC_IMM,
		MEM_ADDR,
		LOAD_READ,
		LOAD_WRITE,
		STORE_WRITE,
		MEM_DONE,
		SCOND_WRITE,
		BRANCH,
		JUMP
	} ctrlStateT;

endpackage

/* src/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch
	import cpuPkg::*;
(
	input logic Clk,
	input logic rst,
	input instrT instr,
	input logic pcInc,
	input logic instrLoad,
	input logic pcBranch,
	input logic pcJump,
	input wordT jumpTarget,
	output pcT instrAddr,
	output instrT curInstr
);

	pcT pc;
	pcT branchDisp;
	instrT instrQ;
	instrT heldInstr;

	// the branch displacement is the signed low byte of the instruction.
	assign branchDisp = pcT'($signed(curInstr[7:0]));

	// **************************************************
	// Program counter.
	// **************************************************
	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
		end else if (pcJump) begin
			pc <= jumpTarget[PC_WIDTH-1:0];
		end else if (pcBranch) begin
			pc <= pc + branchDisp;
		end else if (pcInc) begin
			pc <= pc + 1'b1;
		end
	end

	assign instrAddr = pc;

	// program memory output registered at the end of every cycle.
	// after FETCH it holds the word at the old PC, while the PC already
	// points at the next instruction.
	always_ff @(posedge Clk) begin
		instrQ <= instr;
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			heldInstr <= '0;
		end else if (instrLoad) begin
			heldInstr <= instrQ;
		end
	end

	// during DECODE the word comes straight from the fetch register so
	// control can choose its next state; afterwards it is held.
	assign curInstr = instrLoad ? instrQ : heldInstr;

endmodule

/* src/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl
	import cpuPkg::*;
(
	input logic Clk,
	input logic rst,
	input instrT curInstr,
	input flagsT aluFlags,
	output logic instrLoad,
	output logic pcInc,
	output logic pcBranch,
	output logic pcJump,
	output regAddrT rdAddrA,
	output regAddrT rdAddrB,
	output logic regWe,
	output regAddrT wrAddr,
	output logic [1:0] wrSel,
	output aluOpT aluOp,
	output logic immSel,
	output logic immSigned,
	output wordT imm,
	output logic memWe,
	output logic condBit
);

	ctrlStateT state;
	ctrlStateT nextState;
	flagsT savedFlags;
	logic [3:0] opClass;
	logic [3:0] opExt;
	logic [3:0] fnCode;
	condT condField;
	logic regFnKnown;
	logic immFnKnown;
	logic aluExec;

	assign opClass = curInstr[15:12];
	assign opExt = curInstr[7:4];
	assign fnCode = (opClass == CLASS_REG) ? opExt : opClass;
	assign aluExec = (state == EXEC_REG) || (state == EXEC_IMM);

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= FETCH;
			savedFlags <= '0;
		end else begin
			state <= nextState;
			if (aluExec) begin
				savedFlags <= aluFlags;
			end
		end
	end

	// register-form extensions with no ALU meaning; anything else defaults to LSH.
	always_comb begin
		case (opExt)
			4'b0000, 4'b1000, 4'b1100, 4'b1101, 4'b1111: regFnKnown = 1'b0;
			default: regFnKnown = 1'b1;
		endcase
	end

	always_comb begin
		case (opClass)
			FN_AND, FN_OR, FN_XOR, FN_ADD, FN_ADDU,
			FN_ADDC, FN_SUB, FN_SUBC, FN_CMP, FN_MUL: immFnKnown = 1'b1;
			default: immFnKnown = 1'b0;
		endcase
	end

	// **************************************************
	// Sequencer.
	// **************************************************
	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				if (opClass == CLASS_REG) begin
					nextState = regFnKnown ? OPERAND : FETCH;
				end else if (immFnKnown) begin
					nextState = OPERAND;
				end else if (opClass == CLASS_MEM) begin
					case (opExt)
						EXT_LOAD, EXT_STOR: nextState = MEM_ADDR;
						EXT_SCOND: nextState = SCOND_WRITE;
						EXT_JCOND: nextState = JUMP;
						default: nextState = FETCH;
					endcase
				end else if (opClass == CLASS_BCOND) begin
					nextState = BRANCH;
				end
			end
			OPERAND: nextState = (opClass == CLASS_REG) ? EXEC_REG : EXEC_IMM;
			MEM_ADDR: nextState = (opExt == EXT_LOAD) ? LOAD_READ : STORE_WRITE;
			LOAD_READ: nextState = LOAD_WRITE;
			LOAD_WRITE: nextState = MEM_DONE;
			STORE_WRITE: nextState = MEM_DONE;
			default: nextState = FETCH;
		endcase
	end

	// carry-in is not modelled, so ADDC and SUBC behave as ADD and SUB.
	always_comb begin
		case (fnCode)
			FN_ADD, FN_ADDU, FN_ADDC: aluOp = OP_ADD;
			FN_SUB, FN_SUBC: aluOp = OP_SUB;
			FN_CMP: aluOp = OP_CMP;
			FN_AND: aluOp = OP_AND;
			FN_OR: aluOp = OP_OR;
			FN_XOR: aluOp = OP_XOR;
			FN_MUL: aluOp = OP_MUL;
			default: aluOp = OP_LSH;
		endcase
	end

	// **************************************************
	// Condition decoder.
	// **************************************************
	assign condField = (opClass == CLASS_MEM && opExt == EXT_SCOND) ?
		curInstr[3:0] : curInstr[11:8];

	always_comb begin
		case (condField)
			COND_EQ: condBit = savedFlags[FLAG_Z];
			COND_NE: condBit = !savedFlags[FLAG_Z];
			COND_CS: condBit = savedFlags[FLAG_C];
			COND_CC: condBit = !savedFlags[FLAG_C];
			COND_LO: condBit = savedFlags[FLAG_L];
			COND_HS: condBit = !savedFlags[FLAG_L];
			COND_LT: condBit = savedFlags[FLAG_N];
			COND_GE: condBit = !savedFlags[FLAG_N];
			COND_FS: condBit = savedFlags[FLAG_F];
			COND_FC: condBit = !savedFlags[FLAG_F];
			COND_HI: condBit = !(savedFlags[FLAG_L] || savedFlags[FLAG_Z]);
			COND_LS: condBit = savedFlags[FLAG_L] || savedFlags[FLAG_Z];
			COND_GT: condBit = !(savedFlags[FLAG_N] || savedFlags[FLAG_Z]);
			COND_LE: condBit = savedFlags[FLAG_N] || savedFlags[FLAG_Z];
			COND_UC: condBit = 1'b1;
			COND_NV: condBit = 1'b0;
			default: condBit = 1'b0;
		endcase
	end

	assign instrLoad = (state == DECODE);
	assign pcInc = (state == FETCH);
	assign pcBranch = (state == BRANCH) && condBit;
	assign pcJump = (state == JUMP) && condBit;

	// port A carries Rdest, or the jump target register in JUMP.
	assign rdAddrA = (state == JUMP) ? curInstr[3:0] : curInstr[11:8];
	assign rdAddrB = curInstr[3:0];
	assign wrAddr = curInstr[11:8];

	// CMP only updates the flags.
	assign regWe = (aluExec && fnCode != FN_CMP) || (state == LOAD_WRITE) ||
		(state == SCOND_WRITE);

	always_comb begin
		case (state)
			LOAD_WRITE: wrSel = WR_MEM;
			SCOND_WRITE: wrSel = WR_COND;
			default: wrSel = WR_ALU;
		endcase
	end

	assign immSel = (state == EXEC_IMM);
	assign immSigned = (opClass != FN_ADDU);
	assign imm = wordT'(curInstr[7:0]);
	assign memWe = (state == STORE_WRITE);

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile
	import cpuPkg::*;
(
	input logic Clk,
	input logic rst,
	input regAddrT rdAddrA,
	input regAddrT rdAddrB,
	output wordT rdDataA,
	output wordT rdDataB,
	input logic regWe,
	input regAddrT wrAddr,
	input wordT wrData
);

	wordT regs [16];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (regWe) begin
			regs[wrAddr] <= wrData;
		end
	end

	// reads are combinational; a write shows up on the next cycle.
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
	import cpuPkg::*;
(
	input wordT a,
	input wordT b,
	input aluOpT aluOp,
	output wordT result,
	output flagsT flags
);

	logic [WORD_WIDTH:0] sum;
	wordT diff;
	logic [3:0] shamt;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = a - b;
	assign shamt = b[3:0];

	always_comb begin
		result = '0;
		flags = '0;
		case (aluOp)
			OP_ADD: begin
				result = sum[WORD_WIDTH-1:0];
				flags[FLAG_C] = sum[WORD_WIDTH];
				flags[FLAG_F] = (a[WORD_WIDTH-1] == b[WORD_WIDTH-1]) &&
					(sum[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
			end
			OP_SUB: begin
				result = diff;
				flags[FLAG_F] = (a[WORD_WIDTH-1] != b[WORD_WIDTH-1]) &&
					(diff[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
			end
			OP_CMP: begin
				result = diff;
				flags[FLAG_L] = (b < a);
				flags[FLAG_N] = ($signed(b) < $signed(a));
			end
			OP_AND: result = a & b;
			OP_OR: result = a | b;
			OP_XOR: result = a ^ b;
			OP_NOT: result = ~a;
			OP_LSH: result = a << shamt;
			OP_RSH: result = a >> shamt;
			OP_ARSH: result = $signed(a) >>> shamt;
			OP_MUL: result = a * b;
			default: result = '0;
		endcase

		// compare sets Z from equality, everything else from a zero result.
		if (aluOp == OP_CMP) begin
			flags[FLAG_Z] = (a == b);
		end else begin
			flags[FLAG_Z] = (result == '0);
		end
	end

endmodule

/* src/dataMem.sv */
`timescale 1ns/1ps

module dataMem
	import cpuPkg::*;
(
	input logic Clk,
	input logic memWe,
	input memAddrT addr,
	input wordT wrData,
	output wordT rdData
);

	wordT mem [MEM_DEPTH];

	always_ff @(posedge Clk) begin
		if (memWe) begin
			mem[addr] <= wrData;
		end
	end

	// registered read, data is valid one cycle after the address.
	always_ff @(posedge Clk) begin
		rdData <= mem[addr];
	end

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
	import cpuPkg::*;
(
	input logic Clk,
	input logic rst,
	input instrT instr,
	output pcT instrAddr,
	output logic retireValid,
	output regAddrT retireAddr,
	output wordT retireData
);

	instrT curInstr;
	logic instrLoad;
	logic pcInc;
	logic pcBranch;
	logic pcJump;
	flagsT aluFlags;
	regAddrT rdAddrA;
	regAddrT rdAddrB;
	regAddrT wrAddr;
	logic regWe;
	logic [1:0] wrSel;
	aluOpT aluOp;
	logic immSel;
	logic immSigned;
	wordT imm;
	logic memWe;
	logic condBit;
	wordT rdDataA;
	wordT rdDataB;
	wordT immExt;
	wordT aluB;
	wordT aluResult;
	wordT memRdData;
	wordT wrData;
	memAddrT memAddr;

	// **************************************************
	// Operand and write-back selection.
	// **************************************************
	assign immExt = immSigned ? wordT'($signed(imm[7:0])) : imm;
	assign aluB = immSel ? immExt : rdDataB;
	assign memAddr = memAddrT'(rdDataB);

	always_comb begin
		case (wrSel)
			WR_MEM: wrData = memRdData;
			WR_COND: wrData = wordT'(condBit);
			default: wrData = aluResult;
		endcase
	end

	// the retire port is the register file write port.
	assign retireValid = regWe;
	assign retireAddr = wrAddr;
	assign retireData = wrData;

	instrFetch fetch (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.pcInc(pcInc),
		.instrLoad(instrLoad),
		.pcBranch(pcBranch),
		.pcJump(pcJump),
		.jumpTarget(rdDataA),
		.instrAddr(instrAddr),
		.curInstr(curInstr)
	);

	cpuControl control (
		.Clk(Clk),
		.rst(rst),
		.curInstr(curInstr),
		.aluFlags(aluFlags),
		.instrLoad(instrLoad),
		.pcInc(pcInc),
		.pcBranch(pcBranch),
		.pcJump(pcJump),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.regWe(regWe),
		.wrAddr(wrAddr),
		.wrSel(wrSel),
		.aluOp(aluOp),
		.immSel(immSel),
		.immSigned(immSigned),
		.imm(imm),
		.memWe(memWe),
		.condBit(condBit)
	);

	regFile regs (
		.Clk(Clk),
		.rst(rst),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.regWe(regWe),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	aluUnit alu (
		.a(rdDataA),
		.b(aluB),
		.aluOp(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

	// store data comes from Rdest on port A, the address from Rsrc on port B.
	dataMem dmem (
		.Clk(Clk),
		.memWe(memWe),
		.addr(memAddr),
		.wrData(rdDataA),
		.rdData(memRdData)
	);

endmodule

/* verification/cpuTop_props.sv */
`timescale 1ns/1ps

module cpuTop_props
	import cpuPkg::*;
(
	input logic Clk,
	input logic rst,
	input logic regWe,
	input logic memWe,
	input logic instrLoad,
	input logic pcBranch,
	input logic pcJump,
	input logic retireValid,
	input pcT instrAddr
);

	int failCount = 0;

	// every writing state is followed by FETCH or MEM_DONE, which never write.
	retireSingle: assert property (@(posedge Clk) disable iff (rst)
		retireValid |=> !retireValid)
	else begin
		failCount++;
		$error("retireValid was high on two consecutive cycles");
	end

	strobesInReset: assert property (@(posedge Clk)
		rst && $past(rst) |-> !regWe && !memWe)
	else begin
		failCount++;
		$error("a write strobe was high during reset");
	end

	// the PC only moves on the edge from FETCH into DECODE, or on a taken branch or jump.
	pcStep: assert property (@(posedge Clk) disable iff (rst)
		instrAddr != $past(instrAddr) |-> instrLoad || $past(pcBranch || pcJump))
	else begin
		failCount++;
		$error("instrAddr changed outside FETCH or a taken branch or jump");
	end

endmodule

bind cpuTop cpuTop_props propsCheck (
	.Clk(Clk),
	.rst(rst),
	.regWe(regWe),
	.memWe(memWe),
	.instrLoad(instrLoad),
	.pcBranch(pcBranch),
	.pcJump(pcJump),
	.retireValid(retireValid),
	.instrAddr(instrAddr)
);

/* verification/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb
	import cpuPkg::*;
();

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 5;
	localparam int IMAGE_DEPTH = 128;
	localparam int EXP_BASE = 64;
	localparam logic [23:0] EXP_END = 24'hffffff;
	localparam int WATCH_MARGIN = 100;
	localparam int DRAIN_CYCLES = 8;

	logic Clk;
	logic rst;
	instrT instr;
	pcT instrAddr;
	logic retireValid;
	regAddrT retireAddr;
	wordT retireData;

	// program words sit below EXP_BASE, expected records from EXP_BASE on.
	logic [23:0] image [IMAGE_DEPTH];
	instrT prog [2**PC_WIDTH];
	int progWords = 0;
	int expectCount = 0;
	int retireCount = 0;
	int errorCount = 0;
	int groupChecked = 0;
	int groupErrors = 0;
	int totalErrors = 0;
	bit loaded = 1'b0;

	cpuTop i_dut (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.instrAddr(instrAddr),
		.retireValid(retireValid),
		.retireAddr(retireAddr),
		.retireData(retireData)
	);

	// the program memory is combinational, as the core expects.
	assign instr = prog[instrAddr];

	initial begin
		Clk = 1'b0;
		forever #CLK_HALF Clk = ~Clk;
	end

	function automatic string groupName(input logic [3:0] id);
		case (id)
			4'd1: return "immediate ALU";
			4'd2: return "register ALU";
			4'd3: return "store and load";
			4'd4: return "compare and set";
			4'd5: return "branch and jump";
			default: return "unnamed";
		endcase
	endfunction

	task automatic loadImage();
		for (int i = 0; i < IMAGE_DEPTH; i++) begin
			image[i] = '0;
		end
		for (int i = 0; i < 2**PC_WIDTH; i++) begin
			prog[i] = '0;
		end
		$readmemh("verification/cpu_testdata.txt", image);
		for (int i = 0; i < EXP_BASE; i++) begin
			prog[i] = image[i][15:0];
		end
		// a zero word decodes as an unknown instruction, so it ends the program.
		while (progWords < EXP_BASE && image[progWords] != '0) begin
			progWords++;
		end
		while (EXP_BASE + expectCount < IMAGE_DEPTH &&
			image[EXP_BASE + expectCount] !== EXP_END) begin
			expectCount++;
		end
	endtask

	// **************************************************
	// Retire checker.
	// **************************************************
	always @(negedge Clk) begin
		logic [23:0] rec;
		if (!rst && retireValid) begin
			if (retireCount >= expectCount) begin
				$display("unexpected retire of r%0d = %h at time %0t after the expected list ended",
					retireAddr, retireData, $time);
				errorCount++;
			end else begin
				rec = image[EXP_BASE + retireCount];
				groupChecked++;
				if (retireAddr !== rec[19:16] || retireData !== rec[15:0]) begin
					$display("mismatch at time %0t: retire %0d expected r%0d = %h, got r%0d = %h",
						$time, retireCount, rec[19:16], rec[15:0], retireAddr, retireData);
					errorCount++;
					groupErrors++;
				end
				retireCount++;
				if (retireCount == expectCount ||
					image[EXP_BASE + retireCount][23:20] != rec[23:20]) begin
					$display("group %0d (%s): %0d retires checked, %0d mismatches",
						rec[23:20], groupName(rec[23:20]), groupChecked, groupErrors);
					groupChecked = 0;
					groupErrors = 0;
				end
			end
		end
	end

	// **************************************************
	// Main sequence.
	// **************************************************
	initial begin
		rst <= 1'b1;
		loadImage();
		if (progWords == 0 || expectCount == 0) begin
			$display("the data file held no program words or no expected retires");
			errorCount++;
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge Clk);
		rst <= 1'b0;
		wait (retireCount == expectCount);
		// a few idle cycles catch a retire that should never have happened.
		repeat (DRAIN_CYCLES) @(posedge Clk);
		totalErrors = errorCount + i_dut.propsCheck.failCount;
		$display("%0d of %0d retires checked, %0d value errors, %0d assertion failures",
			retireCount, expectCount, errorCount, i_dut.propsCheck.failCount);
		if (totalErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// no instruction takes more than six cycles.
	initial begin
		wait (loaded);
		repeat (RESET_CYCLES + progWords * 6 + WATCH_MARGIN) @(posedge Clk);
		$display("timeout: the core stopped retiring after %0d of %0d expected records",
			retireCount, expectCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sim.f */
src/cpuPkg.sv
src/instrFetch.sv
src/cpuControl.sv
src/regFile.sv
src/aluUnit.sv
src/dataMem.sv
src/cpuTop.sv
verification/cpuTop_props.sv
verification/cpuTb.sv

/* verification/cpu_testdata.txt */
// program: one 16-bit instruction word per entry, from address 00.
// expected retires from address 40: group_register_data, closed by ffffff.
@00
// immediate ADD, ADD, ADDU, SUB, AND, OR, XOR, ADD, MUL
5105 52FD 63F0 9403 133C 2180 320F 5507 E506
// register ADD, SUB, AND, OR, XOR, MUL, LSH after two loads
5612 5703 0657 0695 0613 0627 0635 06E7 0647 01E2
// address setup, two stores, two loads
5840 69C3 4148 4947 4A08 4B07
// CMP r7,r4 with LT LO HI EQ, then CMP r7,#3 with EQ GT LS UC NV
07B4 4CD6 4CD4 4DDA 4DD0 B703 4ED0 4EDC 4CDB 4DDE 4DDF
// taken BEQ skips 25, not-taken BEQ, JUC r0 to 2D, not-taken JNV
C001 5F11 5F22 C001 5F01 502D 4EC0 5F40 5F50 5F10 4FC0 5F01
@40
1_1_0005 1_2_FFFD 1_3_00F0 1_4_FFFD 1_3_0030 1_1_FF85 1_2_FFF2 1_5_0007 1_5_002A
2_6_0012 2_7_0003 2_6_0015 2_6_FFEB 2_6_0020 2_6_0023 2_6_0009 2_6_001B 2_6_00D8
2_1_06BA
3_8_0040 3_9_00C3 3_A_06BA 3_B_00C3
4_C_0001 4_C_0000 4_D_0001 4_D_0000 4_E_0001 4_E_0000 4_C_0001 4_D_0001 4_D_0000
5_F_0022 5_F_0023 5_0_002D 5_F_0033 5_F_0034
ffffff
